//--- rsp_order_top.f
hw/rsp_order_pkg.sv
hw/rob_if.sv
hw/req_tagger.sv
hw/reorder_buffer.sv
hw/wr_mdata_heap.sv
hw/rsp_merge.sv
hw/rsp_order_top.sv
sim/tb_rsp_order.sv

//--- Bender.yml
package:
  name: rsp_order

sources:
  - files:
      - hw/rsp_order_pkg.sv
      - hw/rob_if.sv
      - hw/req_tagger.sv
      - hw/reorder_buffer.sv
      - hw/wr_mdata_heap.sv
      - hw/rsp_merge.sv
      - hw/rsp_order_top.sv
  - target: simulation
    files:
      - sim/tb_rsp_order.sv

//--- sim/tb_rsp_order.sv
// Simulation top that drives the response-ordering shim against an out-of-order memory model

`timescale 1ns/10ps

module tb_rsp_order;
    import rsp_order_pkg::*;

    // Cycle limits for the bounded waits
    localparam int WAIT_LIMIT  = 500;
    localparam int DRAIN_LIMIT = 4000;

    logic   clk;
    logic   rst_n;
    logic   rd_req_valid;
    t_addr  rd_req_addr;
    t_mdata rd_req_mdata;
    logic   wr_req_valid;
    t_addr  wr_req_addr;
    t_data  wr_req_data;
    t_mdata wr_req_mdata;
    logic   almost_full;
    logic   rd_rsp_valid;
    t_data  rd_rsp_data;
    t_mdata rd_rsp_mdata;
    logic   wr_rsp_valid;
    t_mdata wr_rsp_mdata;
    logic   mem_almost_full;
    logic   mem_rd_valid;
    t_addr  mem_rd_addr;
    t_tag   mem_rd_tag;
    logic   mem_wr_valid;
    t_addr  mem_wr_addr;
    t_data  mem_wr_data;
    t_tag   mem_wr_tag;
    logic   mem_rd_rsp_valid;
    t_tag   mem_rd_rsp_tag;
    t_data  mem_rd_rsp_data;
    logic   mem_wr_rsp_valid;
    t_tag   mem_wr_rsp_tag;

    integer seed = 94523;

    // Memory model state
    // The stall and ordering knobs are set by the main sequence
    logic   mem_stall = 1'b0;
    logic   in_order = 1'b0;
    t_tag   mem_rd_tag_q[$];
    t_addr  mem_rd_addr_q[$];
    t_tag   mem_wr_tag_q[$];
    logic   rd_send = 1'b0;
    logic   wr_send = 1'b0;
    t_tag   rd_send_tag = '0;
    t_tag   wr_send_tag = '0;
    t_data  rd_send_data = '0;

    // Scoreboard
    t_mdata exp_rd_mdata_q[$];
    t_data  exp_rd_data_q[$];
    t_mdata exp_wr_q[$];
    t_addr  exp_mem_wr_addr_q[$];
    t_data  exp_mem_wr_data_q[$];
    int     errors = 0;
    int     rd_issued = 0;
    int     wr_issued = 0;
    int     rd_checked = 0;
    int     wr_checked = 0;

    rsp_order_top u_rsp_order_top (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Line that memory holds at an address
    // The bits are mixed so that neighbouring addresses differ widely
    function automatic t_data data_of(input t_addr addr);
        data_of = {addr ^ 32'hc3a5_5a3c, ~{addr[7:0], addr[15:8], addr[23:16], addr[31:24]}};
    endfunction

    // ========================================
    // Out-of-order memory model
    // ========================================

    // Requests are taken at the rising edge and the reply chosen here goes out at the falling edge
    always @(posedge clk)
    begin : memory_model
        int    pick;
        t_addr exp_addr;
        t_data exp_wdata;
        if (mem_rd_valid)
        begin
            mem_rd_tag_q.push_back(mem_rd_tag);
            mem_rd_addr_q.push_back(mem_rd_addr);
        end
        if (mem_wr_valid)
        begin
            mem_wr_tag_q.push_back(mem_wr_tag);
            // Address and line pass through unchanged in request order
            if (exp_mem_wr_addr_q.size() == 0)
            begin
                errors++;
                $display("ERROR: memory write request seen with no client write issued");
            end
            else
            begin
                exp_addr  = exp_mem_wr_addr_q.pop_front();
                exp_wdata = exp_mem_wr_data_q.pop_front();
                if (mem_wr_addr !== exp_addr)
                begin
                    errors++;
                    $display("Mismatch mem_wr_addr: got %h expected %h", mem_wr_addr, exp_addr);
                end
                if (mem_wr_data !== exp_wdata)
                begin
                    errors++;
                    $display("Mismatch mem_wr_data: got %h expected %h", mem_wr_data, exp_wdata);
                end
            end
        end
        rd_send = 1'b0;
        wr_send = 1'b0;
        // Roughly three cycles in four carry a read reply
        if (!mem_stall && mem_rd_tag_q.size() > 0 && ($random(seed) & 3) != 0)
        begin
            if (in_order)
            begin
                pick = 0;
            end
            else
            begin
                pick = $unsigned($random(seed)) % mem_rd_tag_q.size();
            end
            rd_send      = 1'b1;
            rd_send_tag  = mem_rd_tag_q[pick];
            rd_send_data = data_of(mem_rd_addr_q[pick]);
            mem_rd_tag_q.delete(pick);
            mem_rd_addr_q.delete(pick);
        end
        // Write replies always come back shuffled
        if (!mem_stall && mem_wr_tag_q.size() > 0 && ($random(seed) & 1) != 0)
        begin
            pick        = $unsigned($random(seed)) % mem_wr_tag_q.size();
            wr_send     = 1'b1;
            wr_send_tag = mem_wr_tag_q[pick];
            mem_wr_tag_q.delete(pick);
        end
    end

    always @(negedge clk)
    begin
        mem_rd_rsp_valid = rd_send;
        mem_rd_rsp_tag   = rd_send_tag;
        mem_rd_rsp_data  = rd_send_data;
        mem_wr_rsp_valid = wr_send;
        mem_wr_rsp_tag   = wr_send_tag;
    end

    // ========================================
    // Response checking
    // ========================================

    // Outputs are registered and have settled long before the falling edge
    always @(negedge clk)
    begin : compare
        int     found;
        t_mdata exp_mdata;
        t_data  exp_data;
        if (rst_n && rd_rsp_valid)
        begin
            if (exp_rd_mdata_q.size() == 0)
            begin
                errors++;
                $display("ERROR: read response arrived with no read outstanding");
            end
            else
            begin
                exp_mdata = exp_rd_mdata_q.pop_front();
                exp_data  = exp_rd_data_q.pop_front();
                rd_checked++;
                if (rd_rsp_mdata !== exp_mdata)
                begin
                    errors++;
                    $display("Mismatch rd_rsp_mdata: got %h expected %h", rd_rsp_mdata, exp_mdata);
                end
                if (rd_rsp_data !== exp_data)
                begin
                    errors++;
                    $display("Mismatch rd_rsp_data: got %h expected %h", rd_rsp_data, exp_data);
                end
            end
        end
        if (rst_n && wr_rsp_valid)
        begin
            // Any outstanding write may answer and each mdata is consumed once
            found = -1;
            foreach (exp_wr_q[i])
            begin
                if (found < 0 && exp_wr_q[i] === wr_rsp_mdata)
                begin
                    found = i;
                end
            end
            wr_checked++;
            if (found < 0)
            begin
                errors++;
                $display("Mismatch wr_rsp_mdata: got %h, no outstanding write has it", wr_rsp_mdata);
            end
            else
            begin
                exp_wr_q.delete(found);
            end
        end
    end

    // ========================================
    // Stimulus helpers
    // ========================================

    task automatic wait_not_full();
        int waited;
        waited = 0;
        while (almost_full && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (almost_full)
        begin
            errors++;
            $display("ERROR: almost_full stayed high for %0d cycles", WAIT_LIMIT);
        end
    endtask

    // Drives one read in the current cycle and records what the client should get back
    task automatic drive_read(input t_addr addr, input t_mdata mdata);
        rd_req_valid = 1'b1;
        rd_req_addr  = addr;
        rd_req_mdata = mdata;
        exp_rd_mdata_q.push_back(mdata);
        exp_rd_data_q.push_back(data_of(addr));
        rd_issued++;
    endtask

    task automatic issue_read(input t_addr addr, input t_mdata mdata, input bit obey_full);
        @(negedge clk);
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
        if (obey_full)
        begin
            wait_not_full();
        end
        drive_read(addr, mdata);
    endtask

    task automatic issue_write(input t_addr addr, input t_data data, input t_mdata mdata);
        @(negedge clk);
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
        wait_not_full();
        wr_req_valid = 1'b1;
        wr_req_addr  = addr;
        wr_req_data  = data;
        wr_req_mdata = mdata;
        exp_wr_q.push_back(mdata);
        exp_mem_wr_addr_q.push_back(addr);
        exp_mem_wr_data_q.push_back(data);
        wr_issued++;
    endtask

    task automatic end_requests();
        @(negedge clk);
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_rd_mdata_q.size() != 0 || exp_wr_q.size() != 0) && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_rd_mdata_q.size() != 0 || exp_wr_q.size() != 0)
        begin
            errors++;
            $display("ERROR: %0d reads and %0d writes still unanswered after %0d cycles",
                     exp_rd_mdata_q.size(), exp_wr_q.size(), DRAIN_LIMIT);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        logic rose;
        rst_n = 1'b0;
        rd_req_valid = 1'b0;
        rd_req_addr = '0;
        rd_req_mdata = '0;
        wr_req_valid = 1'b0;
        wr_req_addr = '0;
        wr_req_data = '0;
        wr_req_mdata = '0;
        mem_almost_full = 1'b0;
        mem_rd_rsp_valid = 1'b0;
        mem_rd_rsp_tag = '0;
        mem_rd_rsp_data = '0;
        mem_wr_rsp_valid = 1'b0;
        mem_wr_rsp_tag = '0;

        // Reset holds the client off until both pools report room
        repeat (16) @(negedge clk);
        if (almost_full !== 1'b1)
        begin
            errors++;
            $display("Mismatch almost_full: got %h expected %h during reset", almost_full, 1'b1);
        end
        rst_n = 1'b1;
        @(negedge clk);
        if (rd_rsp_valid !== 1'b0)
        begin
            errors++;
            $display("Mismatch rd_rsp_valid: got %h expected %h after reset", rd_rsp_valid, 1'b0);
        end
        if (wr_rsp_valid !== 1'b0)
        begin
            errors++;
            $display("Mismatch wr_rsp_valid: got %h expected %h after reset", wr_rsp_valid, 1'b0);
        end
        wait_not_full();

        // In-order memory replies
        in_order = 1'b1;
        for (int i = 0; i < 12; i++)
        begin
            issue_read(t_addr'($random(seed)), t_mdata'($random(seed)), 1'b1);
        end
        end_requests();
        wait_drain();

        // Shuffled read replies
        in_order = 1'b0;
        for (int i = 0; i < 24; i++)
        begin
            issue_read(t_addr'($random(seed)), t_mdata'($random(seed)), 1'b1);
        end
        end_requests();
        wait_drain();

        // Shuffled write replies with random mdata
        for (int i = 0; i < 24; i++)
        begin
            issue_write(t_addr'($random(seed)), {$random(seed), $random(seed)},
                        t_mdata'($random(seed)));
        end
        end_requests();
        wait_drain();

        // Memory holds all reads until the read pool pushes almost_full up
        mem_stall = 1'b1;
        rose = 1'b0;
        for (int i = 0; i < N_TAGS && !rose; i++)
        begin
            @(negedge clk);
            rd_req_valid = 1'b0;
            if (almost_full)
            begin
                rose = 1'b1;
            end
            else
            begin
                drive_read(t_addr'($random(seed)), t_mdata'($random(seed)));
            end
        end
        if (!rose)
        begin
            errors++;
            $display("ERROR: almost_full never rose with %0d reads outstanding", rd_issued);
        end
        // The client is still allowed its slack after the level rises
        for (int i = 0; i < ALMFULL_SLACK; i++)
        begin
            issue_read(t_addr'($random(seed)), t_mdata'($random(seed)), 1'b0);
        end
        end_requests();
        if (exp_rd_mdata_q.size() > N_TAGS)
        begin
            errors++;
            $display("ERROR: %0d reads outstanding, more than the %0d tags",
                     exp_rd_mdata_q.size(), N_TAGS);
        end
        mem_stall = 1'b0;
        wait_drain();

        // Memory flag alone raises the shared level
        @(negedge clk);
        mem_almost_full = 1'b1;
        @(negedge clk);
        if (almost_full !== 1'b1)
        begin
            errors++;
            $display("Mismatch almost_full: got %h expected %h", almost_full, 1'b1);
        end
        mem_almost_full = 1'b0;
        @(negedge clk);
        if (almost_full !== 1'b0)
        begin
            errors++;
            $display("Mismatch almost_full: got %h expected %h", almost_full, 1'b0);
        end

        // Mixed traffic under random delay
        for (int i = 0; i < 64; i++)
        begin
            if (($random(seed) & 1) != 0)
            begin
                issue_read(t_addr'($random(seed)), t_mdata'($random(seed)), 1'b1);
            end
            else
            begin
                issue_write(t_addr'($random(seed)), {$random(seed), $random(seed)},
                            t_mdata'($random(seed)));
            end
        end
        end_requests();
        wait_drain();

        // Idle a while so that a stray response would still be caught
        repeat (20) @(negedge clk);
        if (rd_checked != rd_issued || wr_checked != wr_issued)
        begin
            errors++;
            $display("ERROR: response count differs from requests issued");
        end
        $display("Summary: %0d errors, %0d/%0d reads, %0d/%0d writes answered", errors,
                 rd_checked, rd_issued, wr_checked, wr_issued);
        if (errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/rsp_order_top.sv
// Top level of the response-ordering shim with plain client and memory ports

`timescale 1ns/10ps

module rsp_order_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // Client requests
    input  logic                  rd_req_valid,
    input  rsp_order_pkg::t_addr  rd_req_addr,
    input  rsp_order_pkg::t_mdata rd_req_mdata,
    input  logic                  wr_req_valid,
    input  rsp_order_pkg::t_addr  wr_req_addr,
    input  rsp_order_pkg::t_data  wr_req_data,
    input  rsp_order_pkg::t_mdata wr_req_mdata,
    output logic                  almost_full,

    // Client responses
    output logic                  rd_rsp_valid,
    output rsp_order_pkg::t_data  rd_rsp_data,
    output rsp_order_pkg::t_mdata rd_rsp_mdata,
    output logic                  wr_rsp_valid,
    output rsp_order_pkg::t_mdata wr_rsp_mdata,

    // Memory requests
    input  logic                  mem_almost_full,
    output logic                  mem_rd_valid,
    output rsp_order_pkg::t_addr  mem_rd_addr,
    output rsp_order_pkg::t_tag   mem_rd_tag,
    output logic                  mem_wr_valid,
    output rsp_order_pkg::t_addr  mem_wr_addr,
    output rsp_order_pkg::t_data  mem_wr_data,
    output rsp_order_pkg::t_tag   mem_wr_tag,

    // Memory responses, in any order
    input  logic                  mem_rd_rsp_valid,
    input  rsp_order_pkg::t_tag   mem_rd_rsp_tag,
    input  rsp_order_pkg::t_data  mem_rd_rsp_data,
    input  logic                  mem_wr_rsp_valid,
    input  rsp_order_pkg::t_tag   mem_wr_rsp_tag
);
    import rsp_order_pkg::*;

    // Tagger to heap
    logic   wr_alloc;
    t_mdata wr_alloc_mdata;
    t_tag   wr_alloc_idx;
    logic   wr_not_full;

    // Heap to merger
    logic   heap_rsp_valid;
    t_mdata heap_rsp_mdata;

    rob_if rob (.clk(clk));

    req_tagger u_req_tagger (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_req_valid    (rd_req_valid),
        .rd_req_addr     (rd_req_addr),
        .rd_req_mdata    (rd_req_mdata),
        .wr_req_valid    (wr_req_valid),
        .wr_req_addr     (wr_req_addr),
        .wr_req_data     (wr_req_data),
        .wr_req_mdata    (wr_req_mdata),
        .mem_almost_full (mem_almost_full),
        .almost_full     (almost_full),
        .mem_rd_valid    (mem_rd_valid),
        .mem_rd_addr     (mem_rd_addr),
        .mem_rd_tag      (mem_rd_tag),
        .mem_wr_valid    (mem_wr_valid),
        .mem_wr_addr     (mem_wr_addr),
        .mem_wr_data     (mem_wr_data),
        .mem_wr_tag      (mem_wr_tag),
        .rob             (rob.alloc),
        .wr_alloc        (wr_alloc),
        .wr_alloc_mdata  (wr_alloc_mdata),
        .wr_alloc_idx    (wr_alloc_idx),
        .wr_not_full     (wr_not_full)
    );

    reorder_buffer u_reorder_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .rob       (rob.store),
        .fill_en   (mem_rd_rsp_valid),
        .fill_idx  (mem_rd_rsp_tag),
        .fill_data (mem_rd_rsp_data)
    );

    // One stage here, the merger register completes the two-cycle path
    wr_mdata_heap #(
        .N_RD_STAGES (1)
    ) u_wr_mdata_heap (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_alloc       (wr_alloc),
        .wr_alloc_mdata (wr_alloc_mdata),
        .wr_alloc_idx   (wr_alloc_idx),
        .wr_not_full    (wr_not_full),
        .rsp_en         (mem_wr_rsp_valid),
        .rsp_idx        (mem_wr_rsp_tag),
        .rsp_valid      (heap_rsp_valid),
        .rsp_mdata      (heap_rsp_mdata)
    );

    rsp_merge u_rsp_merge (
        .rob             (rob.drain),
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_rsp_in_valid (heap_rsp_valid),
        .wr_rsp_in_mdata (heap_rsp_mdata),
        .rd_rsp_valid    (rd_rsp_valid),
        .rd_rsp_data     (rd_rsp_data),
        .rd_rsp_mdata    (rd_rsp_mdata),
        .wr_rsp_valid    (wr_rsp_valid),
        .wr_rsp_mdata    (wr_rsp_mdata)
    );

endmodule

//--- hw/rsp_merge.sv
// Response merger that forms client read and write responses from the buffer head and heap

`timescale 1ns/10ps

module rsp_merge (
    // Buffer head
    rob_if.drain                  rob,

    input  logic                  clk,
    input  logic                  rst_n,

    // Restored write mdata from the heap
    input  logic                  wr_rsp_in_valid,
    input  rsp_order_pkg::t_mdata wr_rsp_in_mdata,

    // Client read response
    output logic                  rd_rsp_valid,
    output rsp_order_pkg::t_data  rd_rsp_data,
    output rsp_order_pkg::t_mdata rd_rsp_mdata,

    // Client write response
    output logic                  wr_rsp_valid,
    output rsp_order_pkg::t_mdata wr_rsp_mdata
);

    // ========================================
    // Read responses
    // ========================================

    // The client has no back-pressure, so a ready head is always taken
    assign rob.deq = rob.first_valid;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_rsp_valid <= 1'b0;
        end
        else
        begin
            rd_rsp_valid <= rob.first_valid;
        end
    end

    // Payload follows the strobe
    always_ff @(posedge clk)
    begin
        rd_rsp_data  <= rob.first_data;
        rd_rsp_mdata <= rob.first_meta;
        wr_rsp_mdata <= wr_rsp_in_mdata;
    end

    // ========================================
    // Write responses
    // ========================================

    // This register is the last stage of the heap readout
    // Heap stage plus this stage gives two cycles from memory response to client
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_rsp_valid <= 1'b0;
        end
        else
        begin
            wr_rsp_valid <= wr_rsp_in_valid;
        end
    end

endmodule

//--- hw/wr_mdata_heap.sv
// Free-list heap holding write mdata by tag until memory returns the write response

`timescale 1ns/10ps

module wr_mdata_heap #(
    // Register stages on the mdata readout, the strobe is delayed to match
    parameter int N_RD_STAGES = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Allocation from the tagger
    input  logic                  wr_alloc,
    input  rsp_order_pkg::t_mdata wr_alloc_mdata,
    output rsp_order_pkg::t_tag   wr_alloc_idx,
    output logic                  wr_not_full,

    // Memory write response, frees the tag
    input  logic                  rsp_en,
    input  rsp_order_pkg::t_tag   rsp_idx,

    // Restored mdata
    output logic                  rsp_valid,
    output rsp_order_pkg::t_mdata rsp_mdata
);
    import rsp_order_pkg::*;

    // Preserved mdata by tag
    t_mdata mdata_mem [N_TAGS];

    // Ring of free tags with separate pop and push pointers
    t_tag   free_list [N_TAGS];
    t_tag   pop_ptr;
    t_tag   push_ptr;
    t_count free_cnt;
    t_count free_next;

    // Readout pipeline
    t_mdata mdata_pipe [N_RD_STAGES];
    logic [N_RD_STAGES-1:0] valid_pipe;

    // The next free tag is always at the pop pointer
    assign wr_alloc_idx = free_list[pop_ptr];

    always_comb
    begin
        case ({wr_alloc, rsp_en})
            2'b10:   free_next = free_cnt - 1'b1;
            2'b01:   free_next = free_cnt + 1'b1;
            default: free_next = free_cnt;
        endcase
    end

    // ========================================
    // Free list
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            // Every tag starts out free
            for (int i = 0; i < N_TAGS; i++)
            begin
                free_list[i] <= t_tag'(i);
            end
            pop_ptr     <= '0;
            push_ptr    <= '0;
            free_cnt    <= t_count'(N_TAGS);
            wr_not_full <= 1'b0;
        end
        else
        begin
            if (wr_alloc)
            begin
                pop_ptr <= pop_ptr + 1'b1;
            end
            if (rsp_en)
            begin
                free_list[push_ptr] <= rsp_idx;
                push_ptr            <= push_ptr + 1'b1;
            end
            free_cnt <= free_next;

            // Same reserve rule as the read pool
            wr_not_full <= (free_next > t_count'(MIN_FREE_SLOTS));
        end
    end

    // ========================================
    // Mdata storage and readout
    // ========================================

    // The first stage reads at the edge where the tag is returned
    // A reuse of that tag writes one edge later at the earliest, so the read is safe
    always_ff @(posedge clk)
    begin
        if (wr_alloc)
        begin
            mdata_mem[wr_alloc_idx] <= wr_alloc_mdata;
        end
        mdata_pipe[0] <= mdata_mem[rsp_idx];
        for (int s = 1; s < N_RD_STAGES; s++)
        begin
            mdata_pipe[s] <= mdata_pipe[s-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_pipe <= '0;
        end
        else
        begin
            valid_pipe[0] <= rsp_en;
            for (int s = 1; s < N_RD_STAGES; s++)
            begin
                valid_pipe[s] <= valid_pipe[s-1];
            end
        end
    end

    assign rsp_valid = valid_pipe[N_RD_STAGES-1];
    assign rsp_mdata = mdata_pipe[N_RD_STAGES-1];

endmodule

//--- hw/reorder_buffer.sv
// Reorder buffer for reads, filled out of order by tag and drained in request order

`timescale 1ns/10ps

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst_n,

    // Allocation, head presentation and retire
    rob_if.store                 rob,

    // Memory read response
    input  logic                 fill_en,
    input  rsp_order_pkg::t_tag  fill_idx,
    input  rsp_order_pkg::t_data fill_data
);
    import rsp_order_pkg::*;

    // Entry storage
    t_data          data_mem [N_TAGS];
    t_mdata         meta_mem [N_TAGS];

    // Line-present flag per entry
    logic [N_TAGS-1:0] valid;

    // Oldest outstanding entry
    t_tag           head;

    // Outstanding entries, the tail itself is owned by the tagger
    t_count         count;
    t_count         count_next;

    // A response for the head entry is arriving right now
    logic           fill_hit;

    // ========================================
    // Storage
    // ========================================

    // Metadata lands at allocation, the line lands when memory answers
    always_ff @(posedge clk)
    begin
        if (rob.alloc_en)
        begin
            meta_mem[rob.alloc_idx] <= rob.alloc_meta;
        end
        if (fill_en)
        begin
            data_mem[fill_idx] <= fill_data;
        end
    end

    // ========================================
    // Scoreboard
    // ========================================

    always_comb
    begin
        case ({rob.alloc_en, rob.deq})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid        <= '0;
            head         <= '0;
            count        <= '0;
            rob.not_full <= 1'b0;
        end
        else
        begin
            if (fill_en)
            begin
                valid[fill_idx] <= 1'b1;
            end

            // Retire after the set above, so a bypassed fill is not left behind
            if (rob.deq)
            begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end

            count <= count_next;

            // Drops once only the reserve is left, which absorbs the client slack
            rob.not_full <= (count_next < t_count'(N_TAGS - MIN_FREE_SLOTS));
        end
    end

    // ========================================
    // Head presentation
    // ========================================

    // A fill aimed at the head is forwarded in its own cycle
    // This saves a cycle on in-order returns
    assign fill_hit = fill_en && (fill_idx == head);

    assign rob.first_valid = valid[head] || fill_hit;
    assign rob.first_data  = valid[head] ? data_mem[head] : fill_data;
    assign rob.first_meta  = meta_mem[head];

endmodule

//--- hw/req_tagger.sv
// Request tagger that swaps client mdata for pool tags and forms the shared almost-full level

`timescale 1ns/10ps

module req_tagger (
    input  logic                  clk,
    input  logic                  rst_n,

    // Client read request
    input  logic                  rd_req_valid,
    input  rsp_order_pkg::t_addr  rd_req_addr,
    input  rsp_order_pkg::t_mdata rd_req_mdata,

    // Client write request
    input  logic                  wr_req_valid,
    input  rsp_order_pkg::t_addr  wr_req_addr,
    input  rsp_order_pkg::t_data  wr_req_data,
    input  rsp_order_pkg::t_mdata wr_req_mdata,

    // Flow control
    input  logic                  mem_almost_full,
    output logic                  almost_full,

    // Memory read request
    output logic                  mem_rd_valid,
    output rsp_order_pkg::t_addr  mem_rd_addr,
    output rsp_order_pkg::t_tag   mem_rd_tag,

    // Memory write request
    output logic                  mem_wr_valid,
    output rsp_order_pkg::t_addr  mem_wr_addr,
    output rsp_order_pkg::t_data  mem_wr_data,
    output rsp_order_pkg::t_tag   mem_wr_tag,

    // Reorder buffer allocation
    rob_if.alloc                  rob,

    // Write heap allocation
    output logic                  wr_alloc,
    output rsp_order_pkg::t_mdata wr_alloc_mdata,
    input  rsp_order_pkg::t_tag   wr_alloc_idx,
    input  logic                  wr_not_full
);
    import rsp_order_pkg::*;

    // Next reorder buffer slot, advanced once per read request
    t_tag rd_tail;

    // ========================================
    // Read channel
    // ========================================

    // Reads retire in order, so the allocation slot is a plain wrapping counter
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_tail <= '0;
        end
        else if (rd_req_valid)
        begin
            rd_tail <= rd_tail + 1'b1;
        end
    end

    // The buffer keeps the mdata at the slot that memory will echo back as the tag
    assign rob.alloc_en   = rd_req_valid;
    assign rob.alloc_meta = rd_req_mdata;
    assign rob.alloc_idx  = rd_tail;

    // Request reaches memory in the same cycle with the tag in place of the mdata
    assign mem_rd_valid = rd_req_valid;
    assign mem_rd_addr  = rd_req_addr;
    assign mem_rd_tag   = rd_tail;

    // ========================================
    // Write channel
    // ========================================

    // Writes can complete in any order, so the heap chooses the tag
    assign wr_alloc       = wr_req_valid;
    assign wr_alloc_mdata = wr_req_mdata;

    assign mem_wr_valid = wr_req_valid;
    assign mem_wr_addr  = wr_req_addr;
    assign mem_wr_data  = wr_req_data;
    assign mem_wr_tag   = wr_alloc_idx;

    // One level throttles both channels so that load/store order holds
    // Both pool levels are registered and sit low through reset
    assign almost_full = mem_almost_full || !rob.not_full || !wr_not_full;

endmodule

//--- hw/rob_if.sv
// Bundle between the request tagger, the reorder buffer and the response merger

`timescale 1ns/10ps

interface rob_if (
    input logic clk
);
    import rsp_order_pkg::*;

    // Allocation side, driven by the tagger once per read request
    logic   alloc_en;
    t_mdata alloc_meta;
    t_tag   alloc_idx;

    // Registered level from the buffer, low when the reserve is reached
    logic   not_full;

    // Oldest outstanding read, presented once its line has arrived
    logic   first_valid;
    t_data  first_data;
    t_mdata first_meta;

    // Retires the head entry
    logic   deq;

    // Tagger side allocates entries in request order
    modport alloc (
        input  clk,
        output alloc_en,
        output alloc_meta,
        output alloc_idx,
        input  not_full
    );

    // Buffer side holds the entries
    modport store (
        input  clk,
        input  alloc_en,
        input  alloc_meta,
        input  alloc_idx,
        output not_full,
        output first_valid,
        output first_data,
        output first_meta,
        input  deq
    );

    // Merger side drains the head
    modport drain (
        input  clk,
        input  first_valid,
        input  first_data,
        input  first_meta,
        output deq
    );

endinterface

//--- hw/rsp_order_pkg.sv
// Shared sizing constants and payload types for the response-ordering shim, imported by each block

package rsp_order_pkg;

    // ========================================
    // Sizing
    // ========================================

    // In-flight reads, and separately in-flight writes
    localparam int N_TAGS = 16;

    // Tag width follows the pool depth
    localparam int TAG_W = $clog2(N_TAGS);

    // Requests the client may still issue after almost_full rises
    localparam int ALMFULL_SLACK = 2;

    // Each pool keeps the slack plus one slot in reserve
    // The extra slot covers the cycle lost to the registered not-full level
    localparam int MIN_FREE_SLOTS = ALMFULL_SLACK + 1;

    // Client metadata width
    localparam int MDATA_W = 16;

    // Width of one data line
    localparam int DATA_W = 64;

    // Request address width
    localparam int ADDR_W = 32;

    // ========================================
    // Types
    // ========================================

    // Index into either tag pool, also carried on the memory tag fields
    typedef logic [TAG_W-1:0] t_tag;

    // Occupancy counter, one bit wider so that a full pool is representable
    typedef logic [TAG_W:0] t_count;

    // Client metadata
    typedef logic [MDATA_W-1:0] t_mdata;

    // Data line
    typedef logic [DATA_W-1:0] t_data;

    // Request address
    typedef logic [ADDR_W-1:0] t_addr;

endpackage
